// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // meaningful widths
    typedef logic [31:0] word_t;
    typedef logic [11:0] addr_t;
    typedef logic [3:0]  index_t;
    typedef logic [5:0]  tag_t;
    typedef logic [9:0]  mem_addr_t;
    typedef logic [1:0]  byte_sel_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [2:0]  cnt_t;

    // MIPS memory opcodes
    localparam opcode_t OP_LW = 6'b100011;
    localparam opcode_t OP_LB = 6'b100000;
    localparam opcode_t OP_SW = 6'b101011;
    localparam opcode_t OP_SB = 6'b101000;

    // geometry
    localparam int DCACHE_LINES = 16;
    localparam int MEM_WORDS    = 1024;

    // latencies
    // the first stall cycle in IDLE counts toward both phases
    localparam int MEM_READ_CYCLES  = 5;
    localparam int MEM_WRITE_CYCLES = 6;
    localparam int MEM_PIPE_STAGES  = MEM_READ_CYCLES - 1;
    localparam cnt_t WB_LAST_CNT    = cnt_t'(MEM_WRITE_CYCLES - 1);
    localparam cnt_t FILL_LAST_CNT  = cnt_t'(MEM_READ_CYCLES - 2);

    typedef struct packed {
        opcode_t opcode;
        addr_t   addr;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic cache_we;
        logic cache_in_select;  // 1 selects processor data
        logic mem_we;
        logic mem_in_select;    // 1 selects the victim address
        logic is_byte;
    } cache_ctrl_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL
    } ctrl_state_e;

    // address field extraction
    function automatic index_t get_index(addr_t addr);
        return addr[5:2];
    endfunction

    function automatic tag_t get_tag(addr_t addr);
        return addr[11:6];
    endfunction

    function automatic byte_sel_t get_byte_sel(addr_t addr);
        return addr[1:0];
    endfunction

endpackage

`default_nettype wire

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst_b,
    input  dcache_pkg::cpu_req_t       req,
    input  wire logic                  hit,
    input  wire logic                  dirty,
    output dcache_pkg::cache_ctrl_t    ctrl,
    output logic                       stall,
    output logic                       reg_write_enable
);

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;
    dcache_pkg::cnt_t        cnt_q;
    dcache_pkg::cnt_t        cnt_d;

    logic is_load;
    logic is_store;
    logic is_byte_op;
    logic is_mem_op;

    // opcode decode
    always_comb begin
        is_load    = (req.opcode == dcache_pkg::OP_LW) || (req.opcode == dcache_pkg::OP_LB);
        is_store   = (req.opcode == dcache_pkg::OP_SW) || (req.opcode == dcache_pkg::OP_SB);
        is_byte_op = (req.opcode == dcache_pkg::OP_LB) || (req.opcode == dcache_pkg::OP_SB);
        is_mem_op  = is_load || is_store;
    end

    always_comb begin
        state_d          = state_q;
        ctrl             = '0;
        ctrl.is_byte     = is_byte_op;
        stall            = 1'b0;
        reg_write_enable = 1'b0;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (is_mem_op) begin
                    if (hit) begin
                        // hits finish in this cycle
                        reg_write_enable     = is_load;
                        ctrl.cache_we        = is_store;
                        ctrl.cache_in_select = is_store;
                    end else begin
                        stall = 1'b1;
                        if (dirty) begin
                            // victim goes out right away
                            ctrl.mem_we        = 1'b1;
                            ctrl.mem_in_select = 1'b1;
                            state_d            = dcache_pkg::WRITEBACK;
                        end else begin
                            state_d = dcache_pkg::FILL;
                        end
                    end
                end
            end

            dcache_pkg::WRITEBACK: begin
                stall = 1'b1;
                // last writeback cycle already points memory at the new line
                if (cnt_q == dcache_pkg::WB_LAST_CNT) begin
                    state_d = dcache_pkg::FILL;
                end else begin
                    ctrl.mem_in_select = 1'b1;
                end
            end

            dcache_pkg::FILL: begin
                stall = 1'b1;
                if (cnt_q == dcache_pkg::FILL_LAST_CNT) begin
                    // memory read data is valid now
                    ctrl.cache_we = 1'b1;
                    state_d       = dcache_pkg::IDLE;
                end
            end

            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    // counter restarts on each state change and rests at zero in IDLE
    always_comb begin
        if ((state_d != state_q) || (state_q == dcache_pkg::IDLE)) begin
            cnt_d = '0;
        end else begin
            cnt_d = dcache_pkg::cnt_t'(cnt_q + 3'd1);
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q <= dcache_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
    input  wire logic                  clk,
    input  wire logic                  rst_b,
    input  dcache_pkg::cpu_req_t       req,
    input  dcache_pkg::cache_ctrl_t    ctrl,
    input  dcache_pkg::word_t          store_word,
    input  dcache_pkg::word_t          mem_rdata,
    output logic                       hit,
    output logic                       dirty,
    output dcache_pkg::tag_t           victim_tag,
    output dcache_pkg::word_t          line_data
);

    logic [dcache_pkg::DCACHE_LINES-1:0] valid_q;
    logic [dcache_pkg::DCACHE_LINES-1:0] dirty_q;
    dcache_pkg::tag_t                    tag_q  [dcache_pkg::DCACHE_LINES];
    dcache_pkg::word_t                   data_q [dcache_pkg::DCACHE_LINES];

    dcache_pkg::index_t idx;
    dcache_pkg::tag_t   req_tag;
    dcache_pkg::word_t  write_word;

    always_comb begin
        idx     = dcache_pkg::get_index(req.addr);
        req_tag = dcache_pkg::get_tag(req.addr);
    end

    // lookup at the request index
    always_comb begin
        hit        = valid_q[idx] && (tag_q[idx] == req_tag);
        dirty      = valid_q[idx] && dirty_q[idx];
        victim_tag = tag_q[idx];
        line_data  = data_q[idx];
    end

    // processor store or refill from memory
    always_comb begin
        if (ctrl.cache_in_select) begin
            write_word = store_word;
        end else begin
            write_word = mem_rdata;
        end
    end

    // line status
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (ctrl.cache_we) begin
            valid_q[idx] <= 1'b1;
            // refills come in clean, processor writes leave the line dirty
            dirty_q[idx] <= ctrl.cache_in_select;
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (ctrl.cache_we) begin
            tag_q[idx]  <= req_tag;
            data_q[idx] <= write_word;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_lane_align (
    input  dcache_pkg::cpu_req_t   req,
    input  wire logic              is_byte,
    input  dcache_pkg::word_t      line_data,
    output dcache_pkg::word_t      rdata,
    output dcache_pkg::word_t      store_word
);

    dcache_pkg::byte_sel_t byte_sel;
    logic [7:0]            load_byte;
    dcache_pkg::word_t     merged;

    always_comb begin
        byte_sel = dcache_pkg::get_byte_sel(req.addr);
    end

    // little endian, lane 0 is bits 7:0
    always_comb begin
        load_byte = line_data[8*byte_sel +: 8];
        if (is_byte) begin
            rdata = {{24{load_byte[7]}}, load_byte};
        end else begin
            rdata = line_data;
        end
    end

    // byte store keeps the other three lanes of the line
    always_comb begin
        merged                   = line_data;
        merged[8*byte_sel +: 8]  = req.wdata[7:0];
        if (is_byte) begin
            store_word = merged;
        end else begin
            store_word = req.wdata;
        end
    end

endmodule

`default_nettype wire

// ==== main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_memory (
    input  wire logic                  clk,
    input  dcache_pkg::mem_addr_t      addr,
    input  dcache_pkg::word_t          wdata,
    input  wire logic                  we,
    output dcache_pkg::word_t          rdata
);

    dcache_pkg::word_t mem      [dcache_pkg::MEM_WORDS];
    dcache_pkg::word_t rd_pipe  [dcache_pkg::MEM_PIPE_STAGES];

    // all words start at zero
    initial begin
        for (int i = 0; i < dcache_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // fixed read latency
    // the first stage samples the array before any write at this edge
    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[addr];
        for (int s = 1; s < dcache_pkg::MEM_PIPE_STAGES; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

    assign rdata = rd_pipe[dcache_pkg::MEM_PIPE_STAGES-1];

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire logic              clk,
    input  wire logic              rst_b,
    input  dcache_pkg::cpu_req_t   req,
    output dcache_pkg::word_t      rdata,
    output logic                   reg_write_enable,
    output logic                   stall
);

    dcache_pkg::cache_ctrl_t ctrl;
    logic                    hit;
    logic                    dirty;
    dcache_pkg::tag_t        victim_tag;
    dcache_pkg::word_t       line_data;
    dcache_pkg::word_t       store_word;
    dcache_pkg::word_t       mem_rdata;
    dcache_pkg::mem_addr_t   mem_addr;

    // victim line address during writeback, requested line otherwise
    always_comb begin
        if (ctrl.mem_in_select) begin
            mem_addr = {victim_tag, dcache_pkg::get_index(req.addr)};
        end else begin
            mem_addr = {dcache_pkg::get_tag(req.addr), dcache_pkg::get_index(req.addr)};
        end
    end

    dcache_ctrl dcache_ctrl_i (
        .clk              (clk),
        .rst_b            (rst_b),
        .req              (req),
        .hit              (hit),
        .dirty            (dirty),
        .ctrl             (ctrl),
        .stall            (stall),
        .reg_write_enable (reg_write_enable)
    );

    dcache_array dcache_array_i (
        .clk        (clk),
        .rst_b      (rst_b),
        .req        (req),
        .ctrl       (ctrl),
        .store_word (store_word),
        .mem_rdata  (mem_rdata),
        .hit        (hit),
        .dirty      (dirty),
        .victim_tag (victim_tag),
        .line_data  (line_data)
    );

    dcache_lane_align dcache_lane_align_i (
        .req        (req),
        .is_byte    (ctrl.is_byte),
        .line_data  (line_data),
        .rdata      (rdata),
        .store_word (store_word)
    );

    main_memory main_memory_i (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (line_data),
        .we    (ctrl.mem_we),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== dcache_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input  wire logic                  clk,
    input  wire logic                  rst_b,
    input  dcache_pkg::ctrl_state_e    state,
    input  dcache_pkg::cpu_req_t       req,
    input  wire logic                  hit,
    input  dcache_pkg::cache_ctrl_t    ctrl,
    input  wire logic                  stall,
    input  wire logic                  reg_write_enable
);

    logic mem_op;

    always_comb begin
        mem_op = (req.opcode == dcache_pkg::OP_LW) || (req.opcode == dcache_pkg::OP_LB) ||
                 (req.opcode == dcache_pkg::OP_SW) || (req.opcode == dcache_pkg::OP_SB);
    end

    // cache and memory strobes never share a cycle
    a_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_b)
        !(ctrl.cache_we && ctrl.mem_we))
        else $error("cache_we and mem_we high together");

    // in IDLE a stall means a memory op that missed
    a_idle_stall_on_miss: assert property (@(posedge clk) disable iff (!rst_b)
        ((state == dcache_pkg::IDLE) && stall) |-> (mem_op && !hit))
        else $error("stall high in IDLE without a miss");

    a_no_write_while_stalled: assert property (@(posedge clk) disable iff (!rst_b)
        !(reg_write_enable && stall))
        else $error("reg_write_enable high while stalled");

endmodule

bind dcache_ctrl dcache_assertions dcache_assertions_i (
    .clk              (clk),
    .rst_b            (rst_b),
    .state            (state_q),
    .req              (req),
    .hit              (hit),
    .ctrl             (ctrl),
    .stall            (stall),
    .reg_write_enable (reg_write_enable)
);

`default_nettype wire

// ==== tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int STALL_TIMEOUT   = 20;
    localparam int RANDOM_ACCESSES = 400;

    typedef struct packed {
        logic [31:0]       stalls;
        logic              rwe;
        dcache_pkg::word_t rdata;
    } expect_t;

    logic                 clk;
    logic                 rst_b;
    dcache_pkg::cpu_req_t req;
    dcache_pkg::word_t    rdata;
    logic                 reg_write_enable;
    logic                 stall;

    // architectural memory contents plus a mirror of each line's status
    dcache_pkg::word_t ref_mem [dcache_pkg::MEM_WORDS];
    logic [5:0]        m_tag [dcache_pkg::DCACHE_LINES];
    logic [15:0]       m_valid;
    logic [15:0]       m_dirty;

    logic [31:0]       lfsr_state;
    expect_t           exp_cur;
    int                got_stalls;
    dcache_pkg::word_t got_rdata;
    logic              got_rwe;
    event              access_done;

    dcache_top dcache_top_i (
        .clk              (clk),
        .rst_b            (rst_b),
        .req              (req),
        .rdata            (rdata),
        .reg_write_enable (reg_write_enable),
        .stall            (stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic dcache_pkg::cpu_req_t build_req(input dcache_pkg::opcode_t op,
                                                       input dcache_pkg::addr_t addr,
                                                       input dcache_pkg::word_t wdata);
        dcache_pkg::cpu_req_t r;
        r.opcode = op;
        r.addr   = addr;
        r.wdata  = wdata;
        return r;
    endfunction

    // expected stall length and load result from the model before the access
    function automatic expect_t expected_result(input dcache_pkg::cpu_req_t r);
        expect_t           e;
        logic [3:0]        idx;
        logic [5:0]        tg;
        logic [9:0]        w;
        int                lane;
        logic signed [7:0] sb;
        logic              is_load;
        logic              is_store;
        idx      = r.addr[5:2];
        tg       = r.addr[11:6];
        w        = r.addr[11:2];
        lane     = int'(r.addr[1:0]);
        is_load  = (r.opcode == dcache_pkg::OP_LW) || (r.opcode == dcache_pkg::OP_LB);
        is_store = (r.opcode == dcache_pkg::OP_SW) || (r.opcode == dcache_pkg::OP_SB);
        e        = '0;
        if (is_load || is_store) begin
            if (m_valid[idx] && (m_tag[idx] == tg)) begin
                e.stalls = 0;
            end else if (m_valid[idx] && m_dirty[idx]) begin
                e.stalls = dcache_pkg::MEM_WRITE_CYCLES + dcache_pkg::MEM_READ_CYCLES;
            end else begin
                e.stalls = dcache_pkg::MEM_READ_CYCLES;
            end
        end
        e.rwe = is_load;
        sb    = ref_mem[w][8*lane +: 8];
        if (r.opcode == dcache_pkg::OP_LB) begin
            e.rdata = 32'(sb);
        end else begin
            e.rdata = ref_mem[w];
        end
        return e;
    endfunction

    task automatic update_model(input dcache_pkg::cpu_req_t r);
        logic [3:0] idx;
        logic [9:0] w;
        int         lane;
        logic       is_store;
        idx      = r.addr[5:2];
        w        = r.addr[11:2];
        lane     = int'(r.addr[1:0]);
        is_store = (r.opcode == dcache_pkg::OP_SW) || (r.opcode == dcache_pkg::OP_SB);
        if (is_store || (r.opcode == dcache_pkg::OP_LW) || (r.opcode == dcache_pkg::OP_LB)) begin
            if (!(m_valid[idx] && (m_tag[idx] == r.addr[11:6]))) begin
                m_valid[idx] = 1'b1;
                m_tag[idx]   = r.addr[11:6];
                m_dirty[idx] = 1'b0;
            end
            if (is_store) begin
                m_dirty[idx] = 1'b1;
                if (r.opcode == dcache_pkg::OP_SB) begin
                    ref_mem[w][8*lane +: 8] = r.wdata[7:0];
                end else begin
                    ref_mem[w] = r.wdata;
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // drive on the falling edge and count stall cycles until the access completes
    task automatic run_access(input dcache_pkg::cpu_req_t r);
        int cycles;
        @(negedge clk);
        exp_cur = expected_result(r);
        update_model(r);
        req    = r;
        cycles = 0;
        #1;
        while (stall === 1'b1) begin
            cycles++;
            if (cycles > STALL_TIMEOUT) begin
                $display("stall stayed high longer than %0d cycles at %0t", STALL_TIMEOUT, $time);
                $display("Testbench failed");
                $fatal(1, "stall timeout");
            end
            @(negedge clk);
            #1;
        end
        got_stalls = cycles;
        got_rdata  = rdata;
        got_rwe    = reg_write_enable;
        -> access_done;
    endtask

    task automatic access_and_check(input dcache_pkg::opcode_t op, input dcache_pkg::addr_t addr,
                                    input dcache_pkg::word_t wdata, input int stalls,
                                    input dcache_pkg::word_t rd);
        run_access(build_req(op, addr, wdata));
        check_value("stall_cycles", got_stalls, stalls);
        if ((op == dcache_pkg::OP_LW) || (op == dcache_pkg::OP_LB)) begin
            check_value("reg_write_enable", 32'(got_rwe), 32'd1);
            check_value("rdata", got_rdata, rd);
        end else begin
            check_value("reg_write_enable", 32'(got_rwe), 32'd0);
        end
    endtask

    // few tags and low indexes so that lines keep conflicting
    task automatic random_req(output dcache_pkg::cpu_req_t r);
        logic [31:0] op_bits;
        logic [31:0] tag_bits;
        logic [31:0] idx_bits;
        logic [31:0] lane_bits;
        logic [31:0] data_bits;
        logic [5:0]  tg;
        take_bits(2, op_bits);
        take_bits(2, tag_bits);
        take_bits(3, idx_bits);
        take_bits(2, lane_bits);
        take_bits(32, data_bits);
        case (tag_bits[1:0])
            2'd0:    tg = 6'h00;
            2'd1:    tg = 6'h15;
            2'd2:    tg = 6'h2a;
            default: tg = 6'h3f;
        endcase
        case (op_bits[1:0])
            2'd0:    r.opcode = dcache_pkg::OP_LW;
            2'd1:    r.opcode = dcache_pkg::OP_LB;
            2'd2:    r.opcode = dcache_pkg::OP_SW;
            default: r.opcode = dcache_pkg::OP_SB;
        endcase
        if ((r.opcode == dcache_pkg::OP_LW) || (r.opcode == dcache_pkg::OP_SW)) begin
            lane_bits = '0;
        end
        r.addr  = {tg, 1'b0, idx_bits[2:0], lane_bits[1:0]};
        r.wdata = data_bits;
    endtask

    // compares every completed access against the reference
    initial begin
        forever begin
            @(access_done);
            check_value("stall_cycles", got_stalls, exp_cur.stalls);
            check_value("reg_write_enable", 32'(got_rwe), 32'(exp_cur.rwe));
            if (exp_cur.rwe) begin
                check_value("rdata", got_rdata, exp_cur.rdata);
            end
        end
    end

    initial begin
        dcache_pkg::cpu_req_t r;
        rst_b      = 1'b0;
        req        = '0;
        lfsr_state = 32'h24fd;
        m_valid    = '0;
        m_dirty    = '0;
        for (int i = 0; i < dcache_pkg::MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < dcache_pkg::DCACHE_LINES; i++) begin
            m_tag[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst_b = 1'b1;

        // quiet after reset with an R-type opcode on the bus
        repeat (4) begin
            @(negedge clk);
            #1;
            check_value("stall", 32'(stall), 32'd0);
            check_value("reg_write_enable", 32'(reg_write_enable), 32'd0);
        end
        // lui, addi, lh and sh are not handled here
        access_and_check(6'h0f, 12'h044, 32'h1234_5678, 0, '0);
        access_and_check(6'h08, 12'h048, 32'h0000_0001, 0, '0);
        access_and_check(6'h21, 12'h04c, 32'h0000_0002, 0, '0);
        access_and_check(6'h29, 12'h050, 32'h0000_0003, 0, '0);

        // store then load the same word
        access_and_check(dcache_pkg::OP_SW, 12'h044, 32'hdead_beef, 5, '0);
        access_and_check(dcache_pkg::OP_LW, 12'h044, 32'h0, 0, 32'hdead_beef);

        // byte lanes
        // upper bits of wdata must not leak in
        access_and_check(dcache_pkg::OP_SW, 12'h100, 32'h1122_3344, 5, '0);
        access_and_check(dcache_pkg::OP_SB, 12'h100, 32'h5555_55a5, 0, '0);
        access_and_check(dcache_pkg::OP_LW, 12'h100, 32'h0, 0, 32'h1122_33a5);
        access_and_check(dcache_pkg::OP_LB, 12'h100, 32'h0, 0, 32'hffff_ffa5);
        access_and_check(dcache_pkg::OP_SB, 12'h101, 32'haaaa_aa6c, 0, '0);
        access_and_check(dcache_pkg::OP_LW, 12'h100, 32'h0, 0, 32'h1122_6ca5);
        access_and_check(dcache_pkg::OP_LB, 12'h101, 32'h0, 0, 32'h0000_006c);
        access_and_check(dcache_pkg::OP_SB, 12'h102, 32'h0000_00f0, 0, '0);
        access_and_check(dcache_pkg::OP_LW, 12'h100, 32'h0, 0, 32'h11f0_6ca5);
        access_and_check(dcache_pkg::OP_LB, 12'h102, 32'h0, 0, 32'hffff_fff0);
        access_and_check(dcache_pkg::OP_SB, 12'h103, 32'hffff_ff07, 0, '0);
        access_and_check(dcache_pkg::OP_LW, 12'h100, 32'h0, 0, 32'h07f0_6ca5);
        access_and_check(dcache_pkg::OP_LB, 12'h103, 32'h0, 0, 32'h0000_0007);

        // 0x088 and 0x0c8 share index 2
        access_and_check(dcache_pkg::OP_SW, 12'h088, 32'hcafe_f00d, 5, '0);
        access_and_check(dcache_pkg::OP_LW, 12'h0c8, 32'h0, 11, 32'h0);
        access_and_check(dcache_pkg::OP_SW, 12'h0c8, 32'h0bad_c0de, 0, '0);
        access_and_check(dcache_pkg::OP_LW, 12'h088, 32'h0, 11, 32'hcafe_f00d);
        access_and_check(dcache_pkg::OP_LW, 12'h0c8, 32'h0, 5, 32'h0bad_c0de);

        for (int i = 0; i < RANDOM_ACCESSES; i++) begin
            random_req(r);
            run_access(r);
        end

        @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
dcache_pkg.sv
dcache_ctrl.sv
dcache_array.sv
dcache_lane_align.sv
main_memory.sv
dcache_top.sv
dcache_assertions.sv
tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_dcache
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_dcache 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Testbench passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
